// ==== hw/sw_config.svh ====
// Sizes and scoring weights shared by the alignment accelerator; include wherever they are used.
`ifndef SW_CONFIG_SVH
`define SW_CONFIG_SVH

// One host memory line.
`define SW_LINE_BYTES 8
`define SW_LINE_BITS  (`SW_LINE_BYTES * 8)

`define SW_FIFO_LINES 4  // Also the limit on outstanding line reads.

`define SW_QUERY_LEN 4

// Linear gap Smith-Waterman weights.
`define SW_MATCH    2
`define SW_MISMATCH (-1)
`define SW_GAP      (-1)

`define SW_SCORE_BITS 16

`endif

// ==== hw/sw_pkg.sv ====
// Channel, configuration and state types of the alignment accelerator, referenced by scoped names.
`default_nettype none
`include "sw_config.svh"

package sw_pkg;

  typedef logic [`SW_LINE_BITS-1:0] line_t;
  typedef logic [7:0] sym_t;
  typedef logic signed [`SW_SCORE_BITS-1:0] score_t;
  typedef logic [$clog2(`SW_FIFO_LINES + 1)-1:0] lcount_t;

  // Element 0 is the first query character.
  typedef sym_t [`SW_QUERY_LEN-1:0] query_t;

  // Addresses are line addresses.
  typedef struct packed {
    logic        start;
    logic [31:0] src_addr;
    logic [15:0] src_lines;
    logic [31:0] dst_addr;
    logic [31:0] dsm_addr;
    query_t      query;
  } host_cfg_t;

  typedef struct packed {
    logic        valid;
    logic [31:0] addr;
  } mem_rd_req_t;

  typedef struct packed {
    logic  valid;
    line_t data;
  } mem_rd_rsp_t;

  typedef struct packed {
    logic        valid;
    logic [31:0] addr;
    line_t       data;
  } mem_wr_req_t;

  typedef struct packed {
    logic valid;
  } mem_wr_rsp_t;

  typedef enum logic [1:0] {RD_IDLE, RD_FETCH, RD_WAIT, RD_FINISH} rd_state_t;

  typedef enum logic [2:0] {WR_IDLE, WR_RESULT, WR_RESULT_ACK, WR_STATUS, WR_DONE} wr_state_t;

endpackage

`default_nettype wire

// ==== hw/sw_line_fifo.sv ====
// Line FIFO between the read channel and the scorer; takes whole lines and hands out single bytes.
`timescale 1ns/1ps
`default_nettype none
`include "sw_config.svh"

module sw_line_fifo (
  input  logic            clk,
  input  logic            reset,
  input  logic            enq_en,
  input  sw_pkg::line_t   enq_data,
  input  logic            deq_en,
  output sw_pkg::sym_t    deq_data,
  output logic            not_empty,
  output sw_pkg::lcount_t line_count
);

  localparam int LINES = `SW_FIFO_LINES;
  localparam int PTR_W = $clog2(LINES);
  localparam int IDX_W = $clog2(`SW_LINE_BYTES);

  sw_pkg::line_t    mem [LINES];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [IDX_W-1:0] byte_idx;
  sw_pkg::lcount_t  count;
  logic             line_free;

  function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(LINES - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign line_free  = deq_en && (byte_idx == IDX_W'(`SW_LINE_BYTES - 1)); // Last byte leaves.
  assign deq_data   = mem[rd_ptr][byte_idx*8 +: 8];  // Byte 0 of a line goes out first.
  assign not_empty  = (count != '0);
  assign line_count = count;

  always_ff @(posedge clk) begin
    if (enq_en) begin
      mem[wr_ptr] <= enq_data;
    end
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      byte_idx <= '0;
      count    <= '0;
    end else begin
      if (enq_en) begin
        wr_ptr <= next_ptr(wr_ptr);
      end
      if (deq_en) begin
        byte_idx <= line_free ? '0 : byte_idx + 1'b1;
      end
      if (line_free) begin
        rd_ptr <= next_ptr(rd_ptr);
      end
      case ({enq_en, line_free})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // The requestor's read accounting must keep every incoming line within capacity.
  a_no_enq_when_full: assert property (@(posedge clk) disable iff (reset)
    enq_en |-> (count < LINES))
    else $error("line FIFO enqueue while full");

endmodule

`default_nettype wire

// ==== hw/sw_score_core.sv ====
// Smith-Waterman scorer; one cell per query character, fed one database byte per valid cycle.
`timescale 1ns/1ps
`default_nettype none
`include "sw_config.svh"

module sw_score_core (
  input  logic           clk,
  input  logic           reset,
  input  sw_pkg::query_t query,
  input  sw_pkg::sym_t   byte_in,
  input  logic           byte_valid,
  output sw_pkg::score_t score
);

  localparam int QLEN = `SW_QUERY_LEN;
  localparam sw_pkg::score_t MATCH_W    = sw_pkg::score_t'(`SW_MATCH);
  localparam sw_pkg::score_t MISMATCH_W = sw_pkg::score_t'(`SW_MISMATCH);
  localparam sw_pkg::score_t GAP_W      = sw_pkg::score_t'(`SW_GAP);

  // Row 0 is the zero boundary of the matrix.
  sw_pkg::score_t h_prev [QLEN+1];
  sw_pkg::score_t h_cur  [QLEN+1];
  sw_pkg::score_t col_best;
  sw_pkg::score_t col_max;
  sw_pkg::score_t max_q;
  logic           col_valid;

  always_comb begin
    sw_pkg::score_t diag;
    sw_pkg::score_t up;
    sw_pkg::score_t left;
    sw_pkg::score_t best;
    h_cur[0] = '0;
    col_best = '0;
    for (int i = 1; i <= QLEN; i++) begin
      diag = h_prev[i-1] + ((query[i-1] == byte_in) ? MATCH_W : MISMATCH_W);
      up   = h_cur[i-1] + GAP_W;  // Cell above in the same column.
      left = h_prev[i] + GAP_W;
      best = '0;
      if (diag > best) best = diag;
      if (up > best) best = up;
      if (left > best) best = left;
      h_cur[i] = best;
      if (best > col_best) col_best = best;
    end
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      h_prev    <= '{default: '0};
      col_max   <= '0;
      col_valid <= 1'b0;
      max_q     <= '0;
    end else begin
      if (byte_valid) begin
        h_prev  <= h_cur;
        col_max <= col_best;
      end
      col_valid <= byte_valid;
      // Second stage folds the column maximum into the running best.
      if (col_valid && (col_max > max_q)) begin
        max_q <= col_max;
      end
    end
  end

  assign score = max_q;

endmodule

`default_nettype wire

// ==== hw/sw_requestor.sv ====
// Host memory requestor; fetches the database lines, feeds the scorer and writes result and status.
`timescale 1ns/1ps
`default_nettype none
`include "sw_config.svh"

module sw_requestor (
  input  logic                clk,
  input  logic                reset,
  input  sw_pkg::host_cfg_t   cfg,
  input  sw_pkg::mem_rd_rsp_t rd_rsp,
  input  sw_pkg::mem_wr_rsp_t wr_rsp,
  input  logic                rd_almost_full,
  input  logic                wr_almost_full,
  output sw_pkg::mem_rd_req_t rd_req,
  output sw_pkg::mem_wr_req_t wr_req,
  output logic                enq_en,
  output sw_pkg::line_t       enq_data,
  output logic                deq_en,
  input  sw_pkg::sym_t        deq_data,
  input  logic                not_empty,
  input  sw_pkg::lcount_t     line_count,
  output sw_pkg::sym_t        byte_out,
  output logic                byte_valid,
  input  sw_pkg::score_t      score
);

  localparam int BCNT_W = 16 + $clog2(`SW_LINE_BYTES);

  typedef logic [BCNT_W-1:0] bcnt_t;

  sw_pkg::rd_state_t rd_state;
  sw_pkg::wr_state_t wr_state;
  sw_pkg::lcount_t   in_flight;  // Issued reads whose line is not yet in the FIFO.
  logic [15:0]       rd_issued;
  bcnt_t             byte_cnt;
  bcnt_t             total_bytes;
  logic              space;
  logic              issue;
  logic              all_sent;

  assign space       = (in_flight + line_count) < `SW_FIFO_LINES;
  assign issue       = (rd_state == sw_pkg::RD_FETCH) && space && !rd_almost_full;
  assign total_bytes = bcnt_t'(cfg.src_lines) * bcnt_t'(`SW_LINE_BYTES);
  assign all_sent    = (rd_state != sw_pkg::RD_IDLE) && (byte_cnt == total_bytes);
  assign deq_en      = not_empty;  // Drain one byte per cycle whenever data is held.

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      rd_state  <= sw_pkg::RD_IDLE;
      rd_req    <= '0;
      rd_issued <= '0;
    end else begin
      rd_req.valid <= issue;
      if (issue) begin
        rd_req.addr <= cfg.src_addr + 32'(rd_issued);
        rd_issued   <= rd_issued + 1'b1;
      end
      case (rd_state)
        sw_pkg::RD_IDLE: begin
          if (cfg.start) begin
            rd_state <= sw_pkg::RD_FETCH;
          end
        end
        sw_pkg::RD_FETCH: begin
          if (!space) begin
            rd_state <= sw_pkg::RD_WAIT;
          end else if (issue && ((32'(rd_issued) + 1) == 32'(cfg.src_lines))) begin
            rd_state <= sw_pkg::RD_FINISH;
          end
        end
        sw_pkg::RD_WAIT: begin
          if (space) begin
            rd_state <= sw_pkg::RD_FETCH;
          end
        end
        default: rd_state <= rd_state;  // Finished until the next reset.
      endcase
    end
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      in_flight  <= '0;
      enq_en     <= 1'b0;
      byte_valid <= 1'b0;
      byte_cnt   <= '0;
    end else begin
      case ({issue, enq_en})
        2'b10:   in_flight <= in_flight + 1'b1;
        2'b01:   in_flight <= in_flight - 1'b1;
        default: in_flight <= in_flight;
      endcase
      enq_en     <= rd_rsp.valid;
      byte_valid <= deq_en;
      if (byte_valid) begin
        byte_cnt <= byte_cnt + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    enq_data <= rd_rsp.data;
    byte_out <= deq_data;
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      wr_state <= sw_pkg::WR_IDLE;
      wr_req   <= '0;
    end else begin
      wr_req.valid <= 1'b0;
      case (wr_state)
        sw_pkg::WR_IDLE: begin
          // The hop into WR_RESULT covers the second scorer stage.
          if (all_sent) begin
            wr_state <= sw_pkg::WR_RESULT;
          end
        end
        sw_pkg::WR_RESULT: begin
          if (!wr_almost_full) begin
            wr_req   <= '{valid: 1'b1, addr: cfg.dst_addr, data: sw_pkg::line_t'(score)};
            wr_state <= sw_pkg::WR_RESULT_ACK;
          end
        end
        sw_pkg::WR_RESULT_ACK: begin
          if (wr_rsp.valid) begin
            wr_state <= sw_pkg::WR_STATUS;
          end
        end
        sw_pkg::WR_STATUS: begin
          if (!wr_almost_full) begin
            wr_req   <= '{valid: 1'b1, addr: cfg.dsm_addr, data: sw_pkg::line_t'(1)};
            wr_state <= sw_pkg::WR_DONE;
          end
        end
        default: wr_state <= wr_state;
      endcase
    end
  end

  // Every read stays inside the source sequence.
  a_rd_in_range: assert property (@(posedge clk) disable iff (reset)
    rd_req.valid |-> ((rd_req.addr - cfg.src_addr) < 32'(cfg.src_lines)))
    else $error("read request past the last source line");

  // A request may only follow a cycle in which the channel had room.
  a_wr_backpressure: assert property (@(posedge clk) disable iff (reset)
    wr_req.valid |-> $past(!wr_almost_full))
    else $error("write request after almost-full");

endmodule

`default_nettype wire

// ==== hw/sw_accel_top.sv ====
// Top of the alignment accelerator; connects requestor, line FIFO and scorer to the host channels.
`timescale 1ns/1ps
`default_nettype none

module sw_accel_top (
  input  logic                clk,
  input  logic                reset,
  input  sw_pkg::host_cfg_t   cfg,
  output sw_pkg::mem_rd_req_t rd_req,
  input  sw_pkg::mem_rd_rsp_t rd_rsp,
  output sw_pkg::mem_wr_req_t wr_req,
  input  sw_pkg::mem_wr_rsp_t wr_rsp,
  input  logic                rd_almost_full,
  input  logic                wr_almost_full
);

  logic            enq_en;
  sw_pkg::line_t   enq_data;
  logic            deq_en;
  sw_pkg::sym_t    deq_data;
  logic            not_empty;
  sw_pkg::lcount_t line_count;
  sw_pkg::sym_t    byte_stream;
  logic            byte_valid;
  sw_pkg::score_t  score;

  sw_requestor i_requestor (
    .clk            (clk),
    .reset          (reset),
    .cfg            (cfg),
    .rd_rsp         (rd_rsp),
    .wr_rsp         (wr_rsp),
    .rd_almost_full (rd_almost_full),
    .wr_almost_full (wr_almost_full),
    .rd_req         (rd_req),
    .wr_req         (wr_req),
    .enq_en         (enq_en),
    .enq_data       (enq_data),
    .deq_en         (deq_en),
    .deq_data       (deq_data),
    .not_empty      (not_empty),
    .line_count     (line_count),
    .byte_out       (byte_stream),
    .byte_valid     (byte_valid),
    .score          (score)
  );

  sw_line_fifo i_fifo (
    .clk        (clk),
    .reset      (reset),
    .enq_en     (enq_en),
    .enq_data   (enq_data),
    .deq_en     (deq_en),
    .deq_data   (deq_data),
    .not_empty  (not_empty),
    .line_count (line_count)
  );

  sw_score_core i_score (
    .clk        (clk),
    .reset      (reset),
    .query      (cfg.query),
    .byte_in    (byte_stream),
    .byte_valid (byte_valid),
    .score      (score)
  );

endmodule

`default_nettype wire

// ==== bench/tb_host_mem.sv ====
// Host memory model for the accelerator testbench; serves line reads, records writes, checks the channels.
`timescale 1ns/1ps
`default_nettype none
`include "sw_config.svh"

module tb_host_mem #(
  parameter int SEED  = 1,
  parameter int DEPTH = 16
) (
  input  logic                clk,
  input  logic                reset,
  input  logic                stress,
  input  sw_pkg::host_cfg_t   cfg,
  input  sw_pkg::line_t       lines [DEPTH],
  input  sw_pkg::mem_rd_req_t rd_req,
  output sw_pkg::mem_rd_rsp_t rd_rsp,
  input  sw_pkg::mem_wr_req_t wr_req,
  output sw_pkg::mem_wr_rsp_t wr_rsp,
  output logic                rd_almost_full,
  output logic                wr_almost_full,
  output sw_pkg::line_t       result_data,
  output logic                result_seen,
  output logic                status_seen,
  output logic [15:0]         reads_seen,
  output logic                proto_error
);

  // A read waiting for its response, kept in request order.
  typedef struct packed {
    logic [31:0] due;
    logic [31:0] addr;
  } pending_rd_t;

  pending_rd_t rd_q [$];
  int unsigned wr_q [$];  // Cycle at which each write response goes out.
  int unsigned cycle;
  int unsigned last_rd_due;
  int unsigned last_wr_due;
  logic        result_acked;
  integer      seed = SEED;

  // Responses stay in order, so a new one is never due before the previous one.
  function automatic int unsigned next_due(input int unsigned last_due);
    int unsigned lat;
    lat = stress ? 1 + ($unsigned($random(seed)) % 8) : 3;
    return (cycle + lat > last_due) ? cycle + lat : last_due + 1;
  endfunction

  task automatic flag_error(input string what);
    $display("%s", what);
    proto_error = 1'b1;
  endtask

  task automatic clear_state();
    rd_q.delete();
    wr_q.delete();
    cycle        = 0;
    last_rd_due  = 0;
    last_wr_due  = 0;
    reads_seen   = '0;
    result_data  = '0;
    result_seen  = 1'b0;
    status_seen  = 1'b0;
    result_acked = 1'b0;
  endtask

  task automatic accept_requests();
    pending_rd_t pend;
    if (rd_req.valid) begin
      assert (!rd_almost_full)
        else flag_error("Read request in the cycle after read almost-full was high.");
      assert ((32'(reads_seen) < 32'(cfg.src_lines)) &&
              (rd_req.addr == cfg.src_addr + 32'(reads_seen)))
        else flag_error("Read address out of order, repeated or past the last source line.");
      pend.due    = next_due(last_rd_due);
      pend.addr   = rd_req.addr;
      last_rd_due = pend.due;
      rd_q.push_back(pend);
      reads_seen = reads_seen + 1'b1;
      assert (rd_q.size() <= `SW_FIFO_LINES)
        else flag_error("More reads in flight than the line FIFO can hold.");
    end
    if (wr_req.valid) begin
      assert (!wr_almost_full)
        else flag_error("Write request in the cycle after write almost-full was high.");
      if (wr_req.addr == cfg.dst_addr) begin
        assert (!result_seen) else flag_error("The result line was written twice.");
        result_data = wr_req.data;
        result_seen = 1'b1;
      end else if (wr_req.addr == cfg.dsm_addr) begin
        assert (result_acked)
          else flag_error("Status line written before the result write was answered.");
        assert (wr_req.data == sw_pkg::line_t'(1))
          else flag_error($sformatf("MISMATCH at %0t: status line %0h, expected 1",
                                    $time, wr_req.data));
        status_seen = 1'b1;
      end else begin
        flag_error($sformatf("Write to unexpected address %0h.", wr_req.addr));
      end
      last_wr_due = next_due(last_wr_due);
      wr_q.push_back(last_wr_due);
    end
  endtask

  task automatic drive_channels();
    pending_rd_t pend;
    rd_rsp = '0;
    wr_rsp = '0;
    if (rd_q.size() > 0 && rd_q[0].due <= cycle) begin
      pend = rd_q.pop_front();
      rd_rsp.valid = 1'b1;
      rd_rsp.data  = lines[pend.addr - cfg.src_addr];
    end
    if (wr_q.size() > 0 && wr_q[0] <= cycle) begin
      wr_q.delete(0);
      wr_rsp.valid = 1'b1;
      result_acked = result_seen;  // The first answer belongs to the result write.
    end
    rd_almost_full = stress && (($random(seed) & 3) == 0);
    wr_almost_full = stress && (($random(seed) & 3) == 0);
  endtask

  initial begin
    rd_rsp         = '0;
    wr_rsp         = '0;
    rd_almost_full = 1'b0;
    wr_almost_full = 1'b0;
    proto_error    = 1'b0;
    clear_state();
    forever begin
      @(posedge clk);
      #1;  // DUT outputs have settled after the edge.
      if (reset) begin
        clear_state();
      end else begin
        cycle = cycle + 1;
        accept_requests();
      end
      #1;
      drive_channels();
    end
  end

endmodule

`default_nettype wire

// ==== bench/tb_sw_accel.sv ====
// Testbench top for the alignment accelerator; runs alignments of several lengths and checks each result.
`timescale 1ns/1ps
`default_nettype none
`include "sw_config.svh"

module tb_sw_accel;

  localparam int SEED        = 32'h2778b09c;
  localparam int CLK_PERIOD  = 20;
  localparam int DRIVE_DELAY = 2;
  localparam int MAX_LINES   = 16;
  localparam int LB          = `SW_LINE_BYTES;
  localparam int QLEN        = `SW_QUERY_LEN;
  localparam int TOTAL_LINES = 5 + 5 + 5 + 1 + 12;
  localparam int NUM_RUNS    = 5;
  // Every run also gets two lines of time for reset, start and the two writes.
  localparam int WATCHDOG_CYCLES = 40 * (TOTAL_LINES + 2 * NUM_RUNS);

  logic                clk;
  logic                reset;
  logic                stress;
  sw_pkg::host_cfg_t   cfg;
  sw_pkg::mem_rd_req_t rd_req;
  sw_pkg::mem_rd_rsp_t rd_rsp;
  sw_pkg::mem_wr_req_t wr_req;
  sw_pkg::mem_wr_rsp_t wr_rsp;
  logic                rd_almost_full;
  logic                wr_almost_full;
  sw_pkg::line_t       db [MAX_LINES];
  sw_pkg::line_t       result_data;
  sw_pkg::line_t       last_result;
  logic                result_seen;
  logic                status_seen;
  logic [15:0]         reads_seen;
  logic                mem_error;
  integer              seed = SEED;
  int                  expected_q [$];
  int                  runs_checked = 0;

  sw_accel_top i_dut (
    .clk            (clk),
    .reset          (reset),
    .cfg            (cfg),
    .rd_req         (rd_req),
    .rd_rsp         (rd_rsp),
    .wr_req         (wr_req),
    .wr_rsp         (wr_rsp),
    .rd_almost_full (rd_almost_full),
    .wr_almost_full (wr_almost_full)
  );

  tb_host_mem #(.SEED(SEED), .DEPTH(MAX_LINES)) i_mem (
    .clk            (clk),
    .reset          (reset),
    .stress         (stress),
    .cfg            (cfg),
    .lines          (db),
    .rd_req         (rd_req),
    .rd_rsp         (rd_rsp),
    .wr_req         (wr_req),
    .wr_rsp         (wr_rsp),
    .rd_almost_full (rd_almost_full),
    .wr_almost_full (wr_almost_full),
    .result_data    (result_data),
    .result_seen    (result_seen),
    .status_seen    (status_seen),
    .reads_seen     (reads_seen),
    .proto_error    (mem_error)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  task automatic stop_on_error(input string what);
    $display("%s", what);
    $display("Done: errors found");
    $fatal(1, "Simulation stopped after the first error.");
  endtask

  function automatic int max_of(input int a, input int b);
    return (a > b) ? a : b;
  endfunction

  // Local alignment score of the query against the first n_lines lines of db.
  function automatic int sw_ref_score(input sw_pkg::query_t q, input int n_lines);
    int           prev [QLEN+1];
    int           cur [QLEN+1];
    int           best;
    int           s;
    sw_pkg::sym_t b;
    best = 0;
    for (int i = 0; i <= QLEN; i++) begin
      prev[i] = 0;
    end
    for (int j = 0; j < n_lines * LB; j++) begin
      b      = db[j / LB][(j % LB) * 8 +: 8];
      cur[0] = 0;
      for (int i = 1; i <= QLEN; i++) begin
        s      = (q[i-1] == b) ? `SW_MATCH : `SW_MISMATCH;
        cur[i] = max_of(max_of(0, prev[i-1] + s),
                        max_of(cur[i-1] + `SW_GAP, prev[i] + `SW_GAP));
        best   = max_of(best, cur[i]);
      end
      prev = cur;
    end
    return best;
  endfunction

  function automatic sw_pkg::query_t make_query(input string text);
    sw_pkg::query_t q;
    for (int i = 0; i < QLEN; i++) begin
      q[i] = text[i];
    end
    return q;
  endfunction

  function automatic sw_pkg::sym_t pick_symbol(input string alphabet);
    int unsigned idx;
    idx = $unsigned($random(seed)) % alphabet.len();
    return alphabet[idx];
  endfunction

  task automatic fill_database(input int n_lines, input string alphabet);
    for (int l = 0; l < MAX_LINES; l++) begin
      db[l] = '0;
      for (int k = 0; k < LB && l < n_lines; k++) begin
        db[l][k*8 +: 8] = pick_symbol(alphabet);
      end
    end
  endtask

  task automatic place_query(input int pos, input string text);
    for (int i = 0; i < QLEN; i++) begin
      db[(pos + i) / LB][((pos + i) % LB) * 8 +: 8] = text[i];
    end
  endtask

  // Resets the DUT, starts one alignment and waits until its result has been checked.
  task automatic run_alignment(input int n_lines, input logic stressed, input string query_text);
    int target;
    target = runs_checked + 1;
    expected_q.push_back(sw_ref_score(make_query(query_text), n_lines));
    @(posedge clk);
    #DRIVE_DELAY;
    reset         = 1'b1;
    stress        = stressed;
    cfg           = '0;
    cfg.src_addr  = 32'h100;
    cfg.src_lines = 16'(n_lines);
    cfg.dst_addr  = 32'h200;
    cfg.dsm_addr  = 32'h300;
    cfg.query     = make_query(query_text);
    repeat (3) @(posedge clk);
    #DRIVE_DELAY;
    reset = 1'b0;
    @(posedge clk);
    #DRIVE_DELAY;
    cfg.start = 1'b1;
    @(posedge clk);
    #DRIVE_DELAY;
    cfg.start = 1'b0;
    while (runs_checked < target) begin
      @(posedge clk);
    end
  endtask

  initial begin : compare_results
    int expected;
    forever begin
      @(posedge status_seen);
      expected = expected_q.pop_front();
      assert (result_seen) else stop_on_error("No result line came before the status line.");
      assert (result_data == sw_pkg::line_t'(expected))
        else stop_on_error($sformatf("MISMATCH at %0t: result %0d, expected %0d",
                                     $time, result_data, expected));
      assert (reads_seen == cfg.src_lines)
        else stop_on_error("Not every source line was read.");
      last_result  = result_data;
      runs_checked = runs_checked + 1;
    end
  end

  always @(posedge mem_error) begin
    stop_on_error("The host memory model found a channel error.");
  end

  initial begin : watchdog
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    stop_on_error("Timeout, the alignment runs did not finish in time.");
  end

  initial begin : stimulus
    sw_pkg::line_t calm_result;
    reset  = 1'b1;
    stress = 1'b0;
    cfg    = '0;
    fill_database(5, "ACGT");
    place_query(13, "GATC");  // Straddles a line boundary.
    run_alignment(5, 1'b0, "GATC");
    calm_result = last_result;
    assert (last_result == sw_pkg::line_t'(`SW_MATCH * QLEN))
      else stop_on_error($sformatf("MISMATCH at %0t: exact match scored %0d",
                                   $time, last_result));
    run_alignment(5, 1'b1, "GATC");
    assert (last_result == calm_result)
      else stop_on_error($sformatf("MISMATCH at %0t: back-pressure changed result to %0d",
                                   $time, last_result));
    fill_database(5, "ACGT");
    run_alignment(5, 1'b0, "WXYZ");
    assert (last_result == '0)
      else stop_on_error($sformatf("MISMATCH at %0t: disjoint query scored %0d",
                                   $time, last_result));
    fill_database(1, "ACGT");
    run_alignment(1, 1'b1, "CAGT");
    fill_database(12, "ACGT");
    place_query(61, "TTAG");
    run_alignment(12, 1'b1, "TTAG");
    if (!mem_error && expected_q.size() == 0) begin
      $display("Done: no errors");
      $finish;
    end else begin
      stop_on_error("Runs ended with an error or an unchecked result.");
    end
  end

endmodule

`default_nettype wire

// ==== project.f ====
+incdir+hw
hw/sw_pkg.sv
hw/sw_line_fifo.sv
hw/sw_score_core.sv
hw/sw_requestor.sv
hw/sw_accel_top.sv
bench/tb_host_mem.sv
bench/tb_sw_accel.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Builds the accelerator testbench with Verilator, runs it and looks for the pass line in the log.
set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log
PASS_LINE="Done: no errors"

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_sw_accel -Mdir obj_dir -f project.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/Vtb_sw_accel > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -qx "$PASS_LINE" "$LOG"; then
  echo "PASS"
  exit 0
fi
echo "FAIL"
exit 1
